// ==== Bender.yml ====
package:
  name: eth_tx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/eth_stream_pkg.sv
      - rtl/eth_line_pkg.sv
      - rtl/eth_crc32.sv
      - rtl/gmii_tx_framer.sv
      - rtl/eth_tx_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/eth_tx_sva.sv
      - bench/eth_tx_tb.sv

// ==== bench/eth_tx_cases.txt ====
# len first_byte user underrun_pos ifg_delay mii_select clk_enable_gaps exp_symbols exp_crc_residue
# first_byte and exp_crc_residue in hex, rest decimal; residue 0 for frames sent with tx_er
46  00 0 0 12 0 0 72  DEBB20E3
10  A0 0 0 12 0 0 72  DEBB20E3
64  10 0 0 12 0 0 76  DEBB20E3
60  F0 0 0 3  0 0 72  DEBB20E3
1   7E 0 0 3  0 0 72  DEBB20E3
20  30 1 0 3  0 0 28  00000000
61  40 0 0 5  0 0 73  DEBB20E3
30  50 0 7 5  0 0 15  00000000
25  60 0 0 0  0 0 72  DEBB20E3
80  70 0 0 4  0 1 92  DEBB20E3
46  00 0 0 12 1 0 72  DEBB20E3
10  A0 0 0 12 1 1 72  DEBB20E3
64  10 0 0 6  1 1 76  DEBB20E3
20  30 1 0 3  1 1 28  00000000
30  50 0 7 5  1 1 15  00000000
1   7E 0 0 2  1 0 72  DEBB20E3
100 C8 0 0 12 0 0 112 DEBB20E3
2   FF 0 0 12 0 1 72  DEBB20E3

// ==== bench/eth_tx_sva.sv ====
// eth_tx_sva: concurrent checks on the framer line symbols and stream handshake, with its bind
`timescale 1ns/1ns

module eth_tx_sva (
    input logic                    clk,
    input logic                    reset_crc,
    input logic                    s_ready,
    input eth_line_pkg::gmii_sym_t line,
    input eth_line_pkg::tx_state_t state
);

    int fail_count = 0;

    // error strobe only inside a frame or on the underrun symbol
    property er_inside_frame;
        @(posedge clk) disable iff (reset_crc)
        line.tx_er |-> (line.tx_en || state == eth_line_pkg::st_wait_end);
    endproperty

    // line quiet right after reset
    property quiet_after_reset;
        @(posedge clk) reset_crc |=> !line.tx_en;
    endproperty

    property no_ready_in_idle;
        @(posedge clk) disable iff (reset_crc)
        state == eth_line_pkg::st_idle |-> !s_ready;
    endproperty

    a_er_inside_frame: assert property (er_inside_frame)
        else begin
            fail_count++;
            $error("tx_er high outside a frame");
        end
    a_quiet_after_reset: assert property (quiet_after_reset)
        else begin
            fail_count++;
            $error("tx_en high in the cycle after reset");
        end
    a_no_ready_in_idle: assert property (no_ready_in_idle)
        else begin
            fail_count++;
            $error("s_ready high while the framer is idle");
        end

endmodule

bind gmii_tx_framer eth_tx_sva u_sva (
    .clk       (clk),
    .reset_crc (reset_crc),
    .s_ready   (s_ready),
    .line      (line),
    .state     (state)
);

// ==== bench/eth_tx_tb.sv ====
// eth_tx_tb: testbench that reads frame cases, drives the stream and checks the line output
`timescale 1ns/1ns

`include "eth_tx_settings.svh"

module eth_tx_tb;

    localparam int MAX_CASES = 32;
    localparam int DRIVE_DELAY = 10;
    localparam int HDR_LEN = `ETH_PREAMBLE_LEN + 1;

    logic                         clk;
    logic                         reset_crc = 1'b1;
    logic                         clk_enable;
    eth_stream_pkg::stream_beat_t s_beat;
    logic                         s_valid;
    logic                         s_ready;
    eth_stream_pkg::tx_cfg_t      cfg;
    eth_line_pkg::gmii_sym_t      line;

    // case table, one entry per data line
    int          len_t [MAX_CASES];
    logic [7:0]  first_t [MAX_CASES];
    int          user_t [MAX_CASES];
    int          urun_t [MAX_CASES];
    int          ifg_t [MAX_CASES];
    int          mii_t [MAX_CASES];
    int          cen_t [MAX_CASES];
    int          cnt_t [MAX_CASES];
    logic [31:0] res_t [MAX_CASES];
    int          n_cases = 0;
    int          cycle_limit = 0;
    int          cycles = 0;
    int          err_count = 0;
    int          frames_done = 0;
    integer      seed = 35;
    // first beat of the current frame accepted
    logic        first_taken = 1'b0;

    // bytes and error flags of the frame on the line
    logic [7:0]  rx_data [$];
    logic        rx_er [$];

    eth_tx_top u_dut (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .clk_enable (clk_enable),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .cfg        (cfg),
        .line       (line)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // reflected CRC-32 one bit at a time, lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c = c >> 1;
            if (fb) begin
                c = c ^ 32'hEDB8_8320;
            end
        end
        return c;
    endfunction

    function automatic logic pick_enable(input int gaps);
        if (gaps == 0) begin
            return 1'b1;
        end
        return ($random(seed) & 7) != 0;
    endfunction

    task automatic read_cases();
        int    fd;
        int    n;
        string text;
        fd = $fopen("bench/eth_tx_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file bench/eth_tx_cases.txt");
            $display("FAIL: see errors above");
            $fatal(1, "no case file");
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            text = "";
            n = $fgets(text, fd);
            if (n > 1 && text.getc(0) != "#") begin
                n = $sscanf(text, "%d %h %d %d %d %d %d %d %h", len_t[n_cases],
                            first_t[n_cases], user_t[n_cases], urun_t[n_cases],
                            ifg_t[n_cases], mii_t[n_cases], cen_t[n_cases],
                            cnt_t[n_cases], res_t[n_cases]);
                if (n == 9) begin
                    n_cases++;
                end
            end
        end
        $fclose(fd);
    endtask

    // one frame, beats advance only on accepted transfers
    task automatic send_frame(input int k);
        int idx;
        bit dropped;
        bit took;
        idx = 0;
        dropped = 1'b0;
        while (idx < len_t[k]) begin
            s_beat.data = first_t[k] + 8'(idx);
            s_beat.last = (idx == len_t[k] - 1);
            s_beat.user = (user_t[k] != 0) && s_beat.last;
            // hold valid low for the underrun until the framer looks at it
            s_valid = !(urun_t[k] > 0 && idx == urun_t[k] && !dropped);
            clk_enable = pick_enable(cen_t[k]);
            #1;
            took = s_valid && s_ready && clk_enable;
            if (!s_valid && s_ready && clk_enable) begin
                dropped = 1'b1;
            end
            if (took && idx == 0) begin
                first_taken = 1'b1;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            if (took) begin
                idx++;
            end
        end
    endtask

    // wait for idle before the configuration changes
    task automatic settle_idle();
        s_valid = 1'b0;
        clk_enable = 1'b1;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (u_dut.u_framer.state != eth_line_pkg::st_idle);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_frame(input int k);
        int          n;
        int          n_data;
        bit          good;
        logic [7:0]  exp_byte;
        logic [31:0] crc;
        n = rx_data.size();
        check_value($sformatf("frame %0d symbol count", k), n, cnt_t[k]);
        good = (user_t[k] == 0) && (urun_t[k] == 0);
        n_data = good ? len_t[k] : ((user_t[k] != 0) ? len_t[k] - 1 : urun_t[k] - 1);
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < n; i++) begin
            if (i < `ETH_PREAMBLE_LEN) begin
                exp_byte = `ETH_PREAMBLE_BYTE;
            end else if (i == `ETH_PREAMBLE_LEN) begin
                exp_byte = `ETH_SFD_BYTE;
            end else begin
                exp_byte = first_t[k] + 8'(i - HDR_LEN);
                crc = crc_step(crc, rx_data[i]);
            end
            // pad bytes are zero
            if (i >= HDR_LEN + n_data) begin
                exp_byte = 8'h00;
            end
            if (i < HDR_LEN + n_data || (good && i < n - 4)) begin
                check_value($sformatf("frame %0d txd[%0d]", k, i), rx_data[i], exp_byte);
            end
            check_value($sformatf("frame %0d tx_er[%0d]", k, i), rx_er[i], !good && i == n - 1);
        end
        if (good) begin
            check_value($sformatf("frame %0d FCS residue", k), crc, res_t[k]);
        end
    endtask

    // line monitor, one symbol per enabled edge
    initial begin
        eth_line_pkg::gmii_sym_t prev_line;
        logic                    en_q;
        logic                    in_frame;
        logic                    nib_odd;
        logic [3:0]              lo_nib;
        logic                    er_nib;
        int                      gap_cycles;
        int                      need;
        int                      gap;
        in_frame = 1'b0;
        nib_odd = 1'b0;
        gap_cycles = 0;
        @(negedge reset_crc);
        prev_line = line;
        forever begin
            @(posedge clk);
            en_q = clk_enable;
            @(negedge clk);
            if (!en_q) begin
                check_value("line while clk_enable low", line, prev_line);
            end else if (line.tx_en) begin
                if (!in_frame) begin
                    if (frames_done > 0) begin
                        need = ifg_t[frames_done - 1];
                        gap = gap_cycles / ((mii_t[frames_done - 1] != 0) ? 2 : 1);
                        check_value("tx_en low symbols", (gap < need) ? gap : need, need);
                    end
                    rx_data.delete();
                    rx_er.delete();
                    nib_odd = 1'b0;
                    first_taken = 1'b0;
                    in_frame = 1'b1;
                end
                if (cfg.mii_select) begin
                    check_value("txd[7:4] in MII mode", line.txd[7:4], 4'h0);
                    if (!nib_odd) begin
                        lo_nib = line.txd[3:0];
                        er_nib = line.tx_er;
                    end else begin
                        rx_data.push_back({line.txd[3:0], lo_nib});
                        rx_er.push_back(er_nib | line.tx_er);
                    end
                    nib_odd = !nib_odd;
                end else begin
                    rx_data.push_back(line.txd);
                    rx_er.push_back(line.tx_er);
                end
                // first beat taken in the last preamble byte time
                if (!nib_odd && rx_data.size() == `ETH_PREAMBLE_LEN - 1) begin
                    check_value($sformatf("frame %0d s_ready before preamble end", frames_done),
                                first_taken, 1'b0);
                end
                if (!nib_odd && rx_data.size() == HDR_LEN) begin
                    check_value($sformatf("frame %0d s_ready by the SFD", frames_done),
                                first_taken, 1'b1);
                end
            end else if (in_frame) begin
                check_frame(frames_done);
                frames_done++;
                in_frame = 1'b0;
                gap_cycles = 1;
            end else begin
                gap_cycles++;
            end
            prev_line = line;
        end
    end

    initial begin
        wait (u_dut.u_framer.u_sva.fail_count != 0);
        $display("a protocol assertion on the framer failed");
        $display("FAIL: see errors above");
        $fatal(1, "assertion failure");
    end

    initial begin
        wait (cycle_limit > 0);
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("timeout: the run hung with no result after %0d cycles", cycles);
                $display("FAIL: see errors above");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        int limit;
        clk_enable = 1'b1;
        s_valid = 1'b0;
        s_beat = '0;
        cfg = '0;
        read_cases();
        if (n_cases == 0) begin
            $display("the case file holds no usable case line");
            $display("FAIL: see errors above");
            $fatal(1, "no cases");
        end
        // two cycles per symbol of every frame and its gap, plus margin
        limit = 100;
        for (int k = 0; k < n_cases; k++) begin
            limit += 2 * (HDR_LEN + ((len_t[k] > `ETH_MIN_FRAME_LEN - 4) ? len_t[k] :
                     `ETH_MIN_FRAME_LEN - 4) + 4 + ifg_t[k]);
        end
        cycle_limit = limit;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset_crc = 1'b0;
        for (int k = 0; k < n_cases; k++) begin
            if (k > 0 && (ifg_t[k] != ifg_t[k - 1] || mii_t[k] != mii_t[k - 1])) begin
                settle_idle();
            end
            cfg.ifg_delay = 8'(ifg_t[k]);
            cfg.mii_select = (mii_t[k] != 0);
            send_frame(k);
        end
        s_valid = 1'b0;
        clk_enable = 1'b1;
        wait (frames_done == n_cases);
        repeat (2) @(posedge clk);
        if (err_count == 0 && u_dut.u_framer.u_sva.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
rtl/eth_stream_pkg.sv
rtl/eth_line_pkg.sv
rtl/eth_crc32.sv
rtl/gmii_tx_framer.sv
rtl/eth_tx_top.sv
bench/eth_tx_sva.sv
bench/eth_tx_tb.sv

// ==== include/eth_tx_settings.svh ====
// frame constants: minimum length, preamble, SFD, padding switch, CRC polynomial
`ifndef ETH_TX_SETTINGS_SVH
`define ETH_TX_SETTINGS_SVH

// minimum frame length on the wire, FCS included
`define ETH_MIN_FRAME_LEN 64

// preamble bytes ahead of the SFD
`define ETH_PREAMBLE_LEN 7
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE 8'hD5

// 1 pads short frames with zeros, 0 sends them as they are
`define ETH_ENABLE_PADDING 1

// IEEE 802.3 CRC-32, normal bit order
`define ETH_CRC_POLY 32'h04C11DB7

`endif

// ==== rtl/eth_crc32.sv ====
// eth_crc32: byte-wide reflected CRC-32 engine with running register
`timescale 1ns/1ns

`include "eth_tx_settings.svh"

module eth_crc32 (
    input  logic        clk,
    input  logic        reset_crc,
    input  logic        crc_clear,
    input  logic        crc_update,
    input  logic [7:0]  crc_data,
    output logic [31:0] crc_value
);

    function automatic logic [31:0] reflect32(input logic [31:0] v);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = v[31-i];
        end
        return r;
    endfunction

    // reflected form of the polynomial for the lsb-first shift
    localparam logic [31:0] POLY_REV = reflect32(`ETH_CRC_POLY);

    // eight galois steps, lsb of the byte enters first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ POLY_REV;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // clear wins over update
    always_ff @(posedge clk) begin
        if (reset_crc || crc_clear) begin
            crc_value <= 32'hFFFF_FFFF;
        end else if (crc_update) begin
            crc_value <= crc_byte(crc_value, crc_data);
        end
    end

endmodule

// ==== rtl/eth_line_pkg.sv ====
// GMII line symbol and transmit FSM state types
package eth_line_pkg;

    // one symbol on the GMII transmit pins
    typedef struct packed {
        logic [7:0] txd;
        logic       tx_en;
        logic       tx_er;
    } gmii_sym_t;

    // transmit FSM states
    typedef enum logic [2:0] {
        st_idle     = 3'd0,
        st_preamble = 3'd1,
        st_payload  = 3'd2,
        st_last     = 3'd3,
        st_pad      = 3'd4,
        st_fcs      = 3'd5,
        // underrun, dropping the rest of the frame
        st_wait_end = 3'd6,
        st_ifg      = 3'd7
    } tx_state_t;

endpackage

// ==== rtl/eth_stream_pkg.sv ====
// stream beat and run-time configuration types for the transmit path
package eth_stream_pkg;

    // one beat of the incoming byte stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        // bad frame mark, only looked at on the last beat
        logic       user;
    } stream_beat_t;

    // configuration, held stable while a frame is in flight
    typedef struct packed {
        // gap length in symbol times
        logic [7:0] ifg_delay;
        logic       mii_select;
    } tx_cfg_t;

endpackage

// ==== rtl/eth_tx_top.sv ====
// eth_tx_top: transmit path top joining the framer and the CRC engine
`timescale 1ns/1ns

module eth_tx_top (
    input  logic                         clk,
    input  logic                         reset_crc,
    input  logic                         clk_enable,
    input  eth_stream_pkg::stream_beat_t s_beat,
    input  logic                         s_valid,
    output logic                         s_ready,
    input  eth_stream_pkg::tx_cfg_t      cfg,
    output eth_line_pkg::gmii_sym_t      line
);

    logic        crc_clear;
    logic        crc_update;
    logic [7:0]  crc_data;
    logic [31:0] crc_value;

    gmii_tx_framer u_framer (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .clk_enable (clk_enable),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .cfg        (cfg),
        .line       (line),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .crc_data   (crc_data),
        .crc_value  (crc_value)
    );

    // running FCS over payload and pad
    eth_crc32 u_crc (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .crc_data   (crc_data),
        .crc_value  (crc_value)
    );

endmodule

// ==== rtl/gmii_tx_framer.sv ====
// gmii_tx_framer: transmit FSM with preamble, pad, FCS, gap, errors, MII split and enable hold
`timescale 1ns/1ns

`include "eth_tx_settings.svh"

module gmii_tx_framer (
    input  logic                        clk,
    input  logic                        reset_crc,
    input  logic                        clk_enable,
    input  eth_stream_pkg::stream_beat_t s_beat,
    input  logic                        s_valid,
    output logic                        s_ready,
    input  eth_stream_pkg::tx_cfg_t     cfg,
    output eth_line_pkg::gmii_sym_t     line,
    output logic                        crc_clear,
    output logic                        crc_update,
    output logic [7:0]                  crc_data,
    input  logic [31:0]                 crc_value
);

    localparam logic [15:0] PRE_LEN = 16'(`ETH_PREAMBLE_LEN);
    // payload plus pad before the FCS
    localparam logic [15:0] PAD_LEN = 16'(`ETH_MIN_FRAME_LEN - 4);

    eth_line_pkg::tx_state_t      state;
    eth_line_pkg::tx_state_t      state_next;
    eth_line_pkg::gmii_sym_t      sym_next;
    eth_stream_pkg::stream_beat_t beat_reg;

    logic [15:0] cnt;
    logic [15:0] cnt_next;
    logic [15:0] cnt_inc;
    logic [15:0] gap_len;
    logic        ready_reg;
    logic        ready_next;
    logic        mii_odd;
    logic [3:0]  mii_hi;
    logic        nib_phase;
    logic        step;
    logic        xfer;
    logic        sym_busy;

    // second nibble cycle of an MII symbol
    assign nib_phase = cfg.mii_select & mii_odd;
    // one symbol step per enabled byte time
    assign step = clk_enable & ~nib_phase;
    // ready register holds through the high nibble, port only open on the step
    assign s_ready = ready_reg & ~nib_phase;
    assign xfer = s_valid & s_ready & clk_enable;

    assign cnt_inc = cnt + 16'd1;
    assign gap_len = {8'd0, cfg.ifg_delay};
    assign sym_busy = (state != eth_line_pkg::st_idle) || (state_next != eth_line_pkg::st_idle);

    always_comb begin
        state_next = state;
        cnt_next = cnt;
        ready_next = 1'b0;
        sym_next = '0;
        crc_clear = 1'b0;
        crc_update = 1'b0;
        crc_data = beat_reg.data;

        if (step) begin
            case (state)
                eth_line_pkg::st_idle: begin
                    crc_clear = 1'b1;
                    if (s_valid) begin
                        sym_next.txd = `ETH_PREAMBLE_BYTE;
                        sym_next.tx_en = 1'b1;
                        cnt_next = 16'd1;
                        state_next = eth_line_pkg::st_preamble;
                    end
                end
                eth_line_pkg::st_preamble: begin
                    crc_clear = 1'b1;
                    sym_next.txd = `ETH_PREAMBLE_BYTE;
                    sym_next.tx_en = 1'b1;
                    cnt_next = cnt_inc;
                    if (cnt == PRE_LEN) begin
                        // SFD goes out while the first beat is taken
                        sym_next.txd = `ETH_SFD_BYTE;
                        cnt_next = '0;
                        if (!s_valid) begin
                            sym_next.tx_er = 1'b1;
                            ready_next = 1'b1;
                            state_next = eth_line_pkg::st_wait_end;
                        end else if (s_beat.last) begin
                            state_next = eth_line_pkg::st_last;
                        end else begin
                            ready_next = 1'b1;
                            state_next = eth_line_pkg::st_payload;
                        end
                    end else if (cnt == PRE_LEN - 16'd1) begin
                        ready_next = 1'b1;
                    end
                end
                eth_line_pkg::st_payload: begin
                    crc_update = 1'b1;
                    sym_next.txd = beat_reg.data;
                    sym_next.tx_en = 1'b1;
                    cnt_next = cnt_inc;
                    if (!s_valid) begin
                        // underrun, flag this symbol and drop the rest
                        sym_next.tx_er = 1'b1;
                        cnt_next = '0;
                        ready_next = 1'b1;
                        state_next = eth_line_pkg::st_wait_end;
                    end else if (s_beat.last) begin
                        state_next = eth_line_pkg::st_last;
                    end else begin
                        ready_next = 1'b1;
                    end
                end
                eth_line_pkg::st_last: begin
                    sym_next.txd = beat_reg.data;
                    sym_next.tx_en = 1'b1;
                    cnt_next = cnt_inc;
                    if (beat_reg.user) begin
                        // bad frame, no pad and no FCS
                        sym_next.tx_er = 1'b1;
                        cnt_next = '0;
                        state_next = eth_line_pkg::st_ifg;
                    end else begin
                        crc_update = 1'b1;
                        if (`ETH_ENABLE_PADDING != 0 && cnt_inc < PAD_LEN) begin
                            state_next = eth_line_pkg::st_pad;
                        end else begin
                            cnt_next = '0;
                            state_next = eth_line_pkg::st_fcs;
                        end
                    end
                end
                eth_line_pkg::st_pad: begin
                    crc_update = 1'b1;
                    crc_data = 8'h00;
                    sym_next.tx_en = 1'b1;
                    cnt_next = cnt_inc;
                    if (cnt_inc >= PAD_LEN) begin
                        cnt_next = '0;
                        state_next = eth_line_pkg::st_fcs;
                    end
                end
                eth_line_pkg::st_fcs: begin
                    // inverted register, low byte first
                    sym_next.txd = ~crc_value[8*cnt[1:0] +: 8];
                    sym_next.tx_en = 1'b1;
                    cnt_next = cnt_inc;
                    if (cnt[1:0] == 2'd3) begin
                        cnt_next = '0;
                        state_next = eth_line_pkg::st_ifg;
                    end
                end
                eth_line_pkg::st_wait_end: begin
                    // gap count runs while beats are dropped
                    crc_clear = 1'b1;
                    ready_next = 1'b1;
                    cnt_next = cnt_inc;
                    if (xfer && s_beat.last) begin
                        ready_next = 1'b0;
                        if (cnt_inc < gap_len) begin
                            state_next = eth_line_pkg::st_ifg;
                        end else begin
                            cnt_next = '0;
                            state_next = eth_line_pkg::st_idle;
                        end
                    end
                end
                eth_line_pkg::st_ifg: begin
                    crc_clear = 1'b1;
                    cnt_next = cnt_inc;
                    if (cnt_inc >= gap_len) begin
                        cnt_next = '0;
                        state_next = eth_line_pkg::st_idle;
                    end
                end
                default: begin
                    state_next = eth_line_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= eth_line_pkg::st_idle;
            cnt <= '0;
            ready_reg <= 1'b0;
            mii_odd <= 1'b0;
            line <= '0;
        end else if (clk_enable) begin
            if (nib_phase) begin
                // high nibble, everything else holds
                mii_odd <= 1'b0;
                line.txd <= {4'h0, mii_hi};
            end else begin
                state <= state_next;
                cnt <= cnt_next;
                ready_reg <= ready_next;
                line.tx_en <= sym_next.tx_en;
                line.tx_er <= sym_next.tx_er;
                if (cfg.mii_select) begin
                    line.txd <= {4'h0, sym_next.txd[3:0]};
                    mii_odd <= sym_busy;
                end else begin
                    line.txd <= sym_next.txd;
                    mii_odd <= 1'b0;
                end
            end
        end
    end

    // held beat and pending high nibble
    always_ff @(posedge clk) begin
        if (xfer) begin
            beat_reg <= s_beat;
        end
        if (step) begin
            mii_hi <= sym_next.txd[7:4];
        end
    end

endmodule
